/* logic/stack_cfg.svh */
`ifndef STACK_CFG_SVH
`define STACK_CFG_SVH

// link flit, tail mark on top of the payload
`define FLIT_W 11
`define PAYLOAD_W 10

// hop count sits in the header payload
`define HOP_W 4
`define HOP_LSB 6

// bd word is last mark plus two payloads
`define BD_WORD_W 21

// buffer depths per output path
`define FWD_FIFO_DEPTH 8
`define BD_FIFO_DEPTH 4

`endif

/* logic/stack_pkg.sv */
`include "stack_cfg.svh"

package stack_pkg;

	// raw flit from the board link, bit 10 is tail
	typedef logic [`FLIT_W-1:0] flit_t;

	// flit without the tail mark
	typedef logic [`PAYLOAD_W-1:0] payload_t;

	// hops left to travel up the stack
	typedef logic [`HOP_W-1:0] hop_t;

	typedef logic [2*`PAYLOAD_W-1:0] bd_data_t; // two flits, first one low
	typedef logic [`BD_WORD_W-1:0] bd_word_t;   // last mark above bd_data_t

	// router FSM
	typedef enum logic [1:0] {
		HEADER,  // waiting for a packet header
		FORWARD, // passing flits to the top link
		PACK_LO, // next payload fills the low half
		PACK_HI  // next payload completes the word
	} router_state_e;

endpackage

/* logic/stream_if.sv */
`timescale 1ns/10ps

interface stream_if #(
	parameter int WIDTH = 10
);
	logic             valid; // source has an item
	logic             ready; // sink takes it this edge
	logic [WIDTH-1:0] data;
	logic             last;  // final item of a packet

	// producer side
	modport source (
		output valid,
		output data,
		output last,
		input  ready
	);

	// consumer side
	modport sink (
		input  valid,
		input  data,
		input  last,
		output ready
	);

endinterface

/* logic/packet_router.sv */
`timescale 1ns/10ps
`include "stack_cfg.svh"

module packet_router (
	input  logic             clk,
	input  logic             reset,
	input  stack_pkg::flit_t link_flit,  // flit from the board below
	input  logic             link_valid,
	output logic             link_ready,
	stream_if.source         fwd,        // upward path with one payload per item
	stream_if.source         bd          // bd path with two payloads per item
	// bd words get their last mark from the tail flit
);
	import stack_pkg::*;

	router_state_e state;
	router_state_e state_next;

	payload_t flit_payload;
	logic     flit_tail;
	hop_t     flit_hop;   // only meaningful in HEADER
	payload_t hdr_rewrite; // header on its way up
	payload_t lo_q;        // held first half of a bd word
	bd_data_t bd_data;
	logic     fwd_emit;    // current flit goes out on fwd
	logic     bd_emit;     // current flit closes a bd word
	logic     accept;      // link handshake this cycle

	// split the flit
	assign flit_tail    = link_flit[`FLIT_W-1];
	assign flit_payload = link_flit[`PAYLOAD_W-1:0];
	assign flit_hop     = flit_payload[`HOP_LSB +: `HOP_W];

	// one hop used up by this board
	always_comb begin
		hdr_rewrite = flit_payload;
		hdr_rewrite[`HOP_LSB +: `HOP_W] = hop_t'(flit_hop - 1'b1);
	end

	// which stream the present flit needs
	always_comb begin
		fwd_emit = 1'b0;
		bd_emit  = 1'b0;
		case (state)
			HEADER:  fwd_emit = (flit_hop != '0); // zero hop header is swallowed
			FORWARD: fwd_emit = 1'b1;
			PACK_LO: bd_emit  = flit_tail;        // lone tail flushes a half word
			PACK_HI: bd_emit  = 1'b1;
			default: ;
		endcase
	end

	// stall only when the needed stream is blocked
	assign link_ready = !(fwd_emit && !fwd.ready) && !(bd_emit && !bd.ready);
	assign accept     = link_valid && link_ready;

	// forward stream straight from the link
	assign fwd.valid = link_valid && fwd_emit;
	assign fwd.data  = (state == HEADER) ? hdr_rewrite : flit_payload;
	assign fwd.last  = flit_tail;

	// bd word with high half zero when the tail lands low
	always_comb begin
		if (state == PACK_HI)
			bd_data = {flit_payload, lo_q};
		else
			bd_data = {{`PAYLOAD_W{1'b0}}, flit_payload};
	end

	assign bd.valid = link_valid && bd_emit;
	assign bd.data  = bd_data;
	assign bd.last  = flit_tail;

	// FSM next state moves only on an accepted flit
	always_comb begin
		state_next = state;
		if (accept) begin
			case (state)
				HEADER: begin
					if (flit_tail)
						state_next = HEADER; // header-only packet
					else if (flit_hop != '0)
						state_next = FORWARD;
					else
						state_next = PACK_LO;
				end
				FORWARD: state_next = flit_tail ? HEADER : FORWARD;
				PACK_LO: state_next = flit_tail ? HEADER : PACK_HI;
				PACK_HI: state_next = flit_tail ? HEADER : PACK_LO;
				default: state_next = HEADER;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= HEADER;
		else
			state <= state_next;
	end

	// park the low half until its partner arrives
	always_ff @(posedge clk) begin
		if (accept && state == PACK_LO && !flit_tail)
			lo_q <= flit_payload;
	end

	// a blocked upward stream keeps its item until the fifo takes it
	a_fwd_hold: assert property (@(posedge clk) disable iff (reset)
		fwd.valid && !fwd.ready |=> fwd.valid && $stable(fwd.data) && $stable(fwd.last));

	// same for a blocked bd word
	a_bd_hold: assert property (@(posedge clk) disable iff (reset)
		bd.valid && !bd.ready |=> bd.valid && $stable(bd.data) && $stable(bd.last));

	// every packet ends back at the header parser
	a_tail_home: assert property (@(posedge clk) disable iff (reset)
		accept && flit_tail |=> state == HEADER);

endmodule

/* logic/stream_fifo.sv */
`timescale 1ns/10ps

module stream_fifo #(
	parameter int WIDTH = 10,
	parameter int DEPTH = 8
) (
	input  logic     clk,
	input  logic     reset,
	stream_if.sink   wr,  // producer side
	stream_if.source rd   // consumer side
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	logic [WIDTH:0]   mem [DEPTH]; // last kept above data
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] count_next;
	logic             full_q;
	logic             empty_q;
	logic             wr_fire;
	logic             rd_fire;

	assign wr.ready = !full_q;
	assign rd.valid = !empty_q;
	assign wr_fire  = wr.valid && wr.ready;
	assign rd_fire  = rd.valid && rd.ready;

	// head entry straight out of the array
	assign {rd.last, rd.data} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_fire)
			mem[wr_ptr] <= {wr.last, wr.data};
	end

	// pointers wrap at DEPTH, not at a power of two
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr_fire)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_fire)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_comb begin
		case ({wr_fire, rd_fire})
			2'b10:   count_next = count + 1'b1;
			2'b01:   count_next = count - 1'b1;
			default: count_next = count; // idle or pass-through
		endcase
	end

	// flags registered from the next count
	always_ff @(posedge clk) begin
		if (reset) begin
			count   <= '0;
			full_q  <= 1'b0;
			empty_q <= 1'b1;
		end else begin
			count   <= count_next;
			full_q  <= (count_next == CNT_W'(DEPTH));
			empty_q <= (count_next == '0);
		end
	end

	a_count_bound: assert property (@(posedge clk) disable iff (reset)
		count <= CNT_W'(DEPTH));

	// stalled head stays put until the consumer takes it
	a_rd_hold: assert property (@(posedge clk) disable iff (reset)
		rd.valid && !rd.ready |=> rd.valid && $stable(rd.data) && $stable(rd.last));

endmodule

/* logic/port_out_stage.sv */
`timescale 1ns/10ps

module port_out_stage #(
	parameter int WIDTH = 10
) (
	input  logic           clk,
	input  logic           reset,
	stream_if.sink         in,         // from the path fifo
	output logic [WIDTH:0] port_data,  // last mark on top
	output logic           port_valid,
	input  logic           port_ready
);
	logic in_fire;

	// slot free, or emptied at this edge
	assign in.ready = !port_valid || port_ready;
	assign in_fire  = in.valid && in.ready;

	// valid flag
	always_ff @(posedge clk) begin
		if (reset)
			port_valid <= 1'b0;
		else if (in_fire)
			port_valid <= 1'b1;
		else if (port_ready)
			port_valid <= 1'b0; // drained, nothing behind it
	end

	// payload, loaded only on a new item
	always_ff @(posedge clk) begin
		if (in_fire)
			port_data <= {in.last, in.data};
	end

	// port word frozen while the far side stalls
	a_port_hold: assert property (@(posedge clk) disable iff (reset)
		port_valid && !port_ready |=> port_valid && $stable(port_data));

endmodule

/* logic/stack_core.sv */
`timescale 1ns/10ps
`include "stack_cfg.svh"

module stack_core (
	input  logic                clk,
	input  logic                reset,
	// bottom link in
	input  stack_pkg::flit_t    bot_in,
	input  logic                bot_valid_in,
	output logic                bot_ready_out,
	// top link out
	output stack_pkg::flit_t    top_out,
	output logic                top_valid_out,
	input  logic                top_ready_in,
	// bd chip out
	output stack_pkg::bd_word_t bd_out_data,
	output logic                bd_out_valid,
	input  logic                bd_out_ready
);

	// upward path, payload only, tail rides on last
	stream_if #(.WIDTH(`PAYLOAD_W)) fwd_raw ();
	stream_if #(.WIDTH(`PAYLOAD_W)) fwd_buf ();

	// bd path, packed pair of payloads
	stream_if #(.WIDTH(`BD_WORD_W-1)) bd_raw ();
	stream_if #(.WIDTH(`BD_WORD_W-1)) bd_buf ();

	// parser and steering
	packet_router u_router (
		.clk        (clk),
		.reset      (reset),
		.link_flit  (bot_in),
		.link_valid (bot_valid_in),
		.link_ready (bot_ready_out),
		.fwd        (fwd_raw),
		.bd         (bd_raw)
	);

	stream_fifo #(.WIDTH(`PAYLOAD_W), .DEPTH(`FWD_FIFO_DEPTH)) u_fwd_fifo (
		.clk   (clk),
		.reset (reset),
		.wr    (fwd_raw),
		.rd    (fwd_buf)
	);

	stream_fifo #(.WIDTH(`BD_WORD_W-1), .DEPTH(`BD_FIFO_DEPTH)) u_bd_fifo (
		.clk   (clk),
		.reset (reset),
		.wr    (bd_raw),
		.rd    (bd_buf)
	);

	// tail mark back into bit 10 of the flit
	port_out_stage #(.WIDTH(`PAYLOAD_W)) u_top_stage (
		.clk        (clk),
		.reset      (reset),
		.in         (fwd_buf),
		.port_data  (top_out),
		.port_valid (top_valid_out),
		.port_ready (top_ready_in)
	);

	// last mark into bit 20 of the bd word
	port_out_stage #(.WIDTH(`BD_WORD_W-1)) u_bd_stage (
		.clk        (clk),
		.reset      (reset),
		.in         (bd_buf),
		.port_data  (bd_out_data),
		.port_valid (bd_out_valid),
		.port_ready (bd_out_ready)
	);

endmodule

/* verif/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD/2) clk = ~clk; // free running
	end

	// held over the first rising edges, dropped on a falling one
	initial begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule

/* verif/stack_core_tb.sv */
`timescale 1ns/10ps
`include "stack_cfg.svh"

module stack_core_tb;
	import stack_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int QTR          = CLK_PERIOD / 4; // sample point after the falling edge
	localparam int NUM_PKTS     = 60;
	localparam int SEED         = 53;
	localparam int DRAIN_CYCLES = 12;
	localparam int WATCHDOG_NS  = NUM_PKTS * 9 * 8 * CLK_PERIOD;

	logic     clk;
	logic     reset;
	flit_t    bot_in;
	logic     bot_valid_in;
	logic     bot_ready_out;
	flit_t    top_out;
	logic     top_valid_out;
	logic     top_ready_in;
	bd_word_t bd_out_data;
	logic     bd_out_valid;
	logic     bd_out_ready;

	flit_t    pkt [0:7]; // packet under construction with header at 0
	int       pkt_len;
	flit_t    exp_top[$]; // expected top link flits
	bd_word_t exp_bd[$];  // expected bd words

	clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clk (
		.clk   (clk),
		.reset (reset)
	);

	stack_core uut (
		.clk           (clk),
		.reset         (reset),
		.bot_in        (bot_in),
		.bot_valid_in  (bot_valid_in),
		.bot_ready_out (bot_ready_out),
		.top_out       (top_out),
		.top_valid_out (top_valid_out),
		.top_ready_in  (top_ready_in),
		.bd_out_data   (bd_out_data),
		.bd_out_valid  (bd_out_valid),
		.bd_out_ready  (bd_out_ready)
	);

	// stop the run with a reason
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic check_value(input string what, input logic [31:0] got,
			input logic [31:0] expected);
		if (got !== expected)
			fail_run($sformatf("ERROR at %0t ns: %s got %h expected %h",
				$time, what, got, expected));
	endtask

	// expected outputs of pkt[0 .. pkt_len-1]
	function automatic void model_packet();
		hop_t     hop;
		payload_t lo;
		payload_t hi;
		logic     last;
		flit_t    f;
		int       i;
		hop = pkt[0][`HOP_LSB +: `HOP_W];
		if (hop != '0) begin
			// forwarded packet loses one hop in the header
			for (i = 0; i < pkt_len; i++) begin
				f = pkt[i];
				if (i == 0)
					f[`HOP_LSB +: `HOP_W] = hop_t'(hop - 1'b1);
				exp_top.push_back(f);
			end
		end else begin
			// delivered packet drops the header and pairs payloads low first
			for (i = 1; i < pkt_len; i += 2) begin
				lo   = pkt[i][`PAYLOAD_W-1:0];
				last = pkt[i][`FLIT_W-1];
				hi   = '0; // odd tail leaves the top half empty
				if (i + 1 < pkt_len) begin
					hi   = pkt[i+1][`PAYLOAD_W-1:0];
					last = last | pkt[i+1][`FLIT_W-1];
				end
				exp_bd.push_back({last, hi, lo});
			end
		end
	endfunction

	// present one flit and hold it until the link takes it
	task automatic send_flit(input flit_t f);
		@(negedge clk);
		bot_in       = f;
		bot_valid_in = 1'b1;
		#(QTR);
		while (!bot_ready_out) begin
			@(negedge clk);
			#(QTR);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk);
			bot_valid_in = 1'b0;
		end
	endtask

	// random back-pressure on both outputs, mostly stalled so the fifos fill
	always @(negedge clk) begin
		top_ready_in = ($urandom_range(0, 3) == 0);
		bd_out_ready = ($urandom_range(0, 3) == 0);
	end

	// scoreboard samples handshakes where they are stable
	always @(negedge clk) begin
		#(QTR);
		if (!reset && top_valid_out && top_ready_in) begin
			if (exp_top.size() == 0)
				fail_run($sformatf("top link sent flit %h that no packet accounts for", top_out));
			check_value("top flit", top_out, exp_top.pop_front());
		end
		if (!reset && bd_out_valid && bd_out_ready) begin
			if (exp_bd.size() == 0)
				fail_run($sformatf("bd port sent word %h that no packet accounts for", bd_out_data));
			check_value("bd word", bd_out_data, exp_bd.pop_front());
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before all packets came out");
		$display("Regression failed");
		$fatal(1, "timeout");
	end

	initial begin
		int       p;
		int       i;
		int       n_pay;
		hop_t     hop;
		payload_t hdr;
		void'($urandom(SEED));
		bot_in       = '0;
		bot_valid_in = 1'b0;
		top_ready_in = 1'b0;
		bd_out_ready = 1'b0;

		// outputs quiet while reset is held
		@(negedge clk);
		#(QTR);
		check_value("top valid in reset", top_valid_out, 0);
		check_value("bd valid in reset", bd_out_valid, 0);
		while (reset)
			@(negedge clk);
		#(QTR);
		check_value("top valid after reset", top_valid_out, 0);
		check_value("bd valid after reset", bd_out_valid, 0);
		check_value("bot ready after reset", bot_ready_out, 1);

		for (p = 0; p < NUM_PKTS; p++) begin
			// first 16 sweep every length on both paths
			if (p < 16)
				n_pay = p % 8;
			else
				n_pay = $urandom_range(0, 7);
			if (p < 8)
				hop = '0;
			else if (p < 16)
				hop = hop_t'($urandom_range(1, 15));
			else if ($urandom_range(0, 1) != 0)
				hop = '0;
			else
				hop = hop_t'($urandom_range(1, 15));
			hdr = payload_t'($urandom);
			hdr[`HOP_LSB +: `HOP_W] = hop;
			pkt[0] = {(n_pay == 0), hdr}; // header-only carries the tail
			for (i = 1; i <= n_pay; i++)
				pkt[i] = {(i == n_pay), payload_t'($urandom)};
			pkt_len = n_pay + 1;
			model_packet();
			for (i = 0; i < pkt_len; i++) begin
				idle_cycles($urandom_range(0, 2));
				send_flit(pkt[i]);
			end
		end
		@(negedge clk);
		bot_valid_in = 1'b0;

		// everything expected has to come out
		while (exp_top.size() != 0 || exp_bd.size() != 0)
			@(negedge clk);
		repeat (DRAIN_CYCLES) @(negedge clk);
		#(QTR);
		if (top_valid_out || bd_out_valid) begin
			$display("output still valid after every expected item was received");
			$display("Regression failed");
			$fatal(1, "leftover output");
		end else begin
			$display("Regression passed");
			$finish;
		end
	end

endmodule

/* verilog.f */
+incdir+logic
logic/stack_pkg.sv
logic/stream_if.sv
logic/packet_router.sv
logic/stream_fifo.sv
logic/port_out_stage.sv
logic/stack_core.sv
verif/clock_gen.sv
verif/stack_core_tb.sv
